// File: design/decode_pkg.sv
// ----------------------------------------------------------
// decode stage package: widths, rv64i encodings, internal
// operation codes and the instruction word views
// ----------------------------------------------------------
`default_nettype none

package decode_pkg;

  localparam int XLEN   = 64;
  localparam int INST_W = 32;
  localparam int REG_AW = 5;
  localparam int OP_W   = 5;

  // major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // internal operation codes, nop must stay zero
  localparam logic [OP_W-1:0] OP_NOP   = 5'd0;
  localparam logic [OP_W-1:0] OP_ADD   = 5'd1;
  localparam logic [OP_W-1:0] OP_SUB   = 5'd2;
  localparam logic [OP_W-1:0] OP_SLL   = 5'd3;
  localparam logic [OP_W-1:0] OP_SLT   = 5'd4;
  localparam logic [OP_W-1:0] OP_SLTU  = 5'd5;
  localparam logic [OP_W-1:0] OP_XOR   = 5'd6;
  localparam logic [OP_W-1:0] OP_SRL   = 5'd7;
  localparam logic [OP_W-1:0] OP_SRA   = 5'd8;
  localparam logic [OP_W-1:0] OP_OR    = 5'd9;
  localparam logic [OP_W-1:0] OP_AND   = 5'd10;
  localparam logic [OP_W-1:0] OP_LUI   = 5'd11;
  localparam logic [OP_W-1:0] OP_AUIPC = 5'd12;
  localparam logic [OP_W-1:0] OP_JAL   = 5'd13;
  localparam logic [OP_W-1:0] OP_JALR  = 5'd14;
  localparam logic [OP_W-1:0] OP_BEQ   = 5'd15;
  localparam logic [OP_W-1:0] OP_BNE   = 5'd16;
  localparam logic [OP_W-1:0] OP_BLT   = 5'd17;
  localparam logic [OP_W-1:0] OP_BGE   = 5'd18;
  localparam logic [OP_W-1:0] OP_BLTU  = 5'd19;
  localparam logic [OP_W-1:0] OP_BGEU  = 5'd20;
  localparam logic [OP_W-1:0] OP_LOAD  = 5'd21;
  localparam logic [OP_W-1:0] OP_STORE = 5'd22;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // b format shares this layout with a scrambled immediate
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
  } inst_word_u;

endpackage

`default_nettype wire

// File: design/dec_if.sv
// ----------------------------------------------------------
// decoded instruction bundle from decoder to stage logic
// ----------------------------------------------------------
`default_nettype none

interface dec_if;

  logic [decode_pkg::OP_W-1:0]   op;
  logic [decode_pkg::REG_AW-1:0] rs1_addr;
  logic [decode_pkg::REG_AW-1:0] rs2_addr;
  logic                          rs1_read;
  logic                          rs2_read;
  logic                          rd_we;
  logic [decode_pkg::REG_AW-1:0] rd_addr;
  logic [decode_pkg::XLEN-1:0]   imm;
  logic                          use_pc;
  logic                          use_imm;
  logic [2:0]                    funct3;

  modport dec (
    output op, rs1_addr, rs2_addr, rs1_read, rs2_read, rd_we, rd_addr,
    output imm, use_pc, use_imm, funct3
  );

  modport user (
    input op, rs1_addr, rs2_addr, rs1_read, rs2_read, rd_we, rd_addr,
    input imm, use_pc, use_imm, funct3
  );

endinterface

`default_nettype wire

// File: design/inst_decoder.sv
// ----------------------------------------------------------
// rv64i instruction decoder: class, operation, register use
// and sign-extended immediate
// ----------------------------------------------------------
`default_nettype none

module inst_decoder (
  input  decode_pkg::inst_word_u inst_i,
  dec_if.dec                     d
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;
  logic       rs1_rd;
  logic       rs2_rd;
  logic       wr;
  logic [decode_pkg::XLEN-1:0] imm_i;
  logic [decode_pkg::XLEN-1:0] imm_s;
  logic [decode_pkg::XLEN-1:0] imm_b;
  logic [decode_pkg::XLEN-1:0] imm_u;
  logic [decode_pkg::XLEN-1:0] imm_j;

  // funct3 to alu op, alt picks sub / sra
  function automatic logic [decode_pkg::OP_W-1:0] alu_op(input logic [2:0] f3,
                                                         input logic       alt_sel);
    case (f3)
      3'b000:  alu_op = alt_sel ? decode_pkg::OP_SUB : decode_pkg::OP_ADD;
      3'b001:  alu_op = decode_pkg::OP_SLL;
      3'b010:  alu_op = decode_pkg::OP_SLT;
      3'b011:  alu_op = decode_pkg::OP_SLTU;
      3'b100:  alu_op = decode_pkg::OP_XOR;
      3'b101:  alu_op = alt_sel ? decode_pkg::OP_SRA : decode_pkg::OP_SRL;
      3'b110:  alu_op = decode_pkg::OP_OR;
      default: alu_op = decode_pkg::OP_AND;
    endcase
  endfunction

  assign opcode = inst_i.r_fmt.opcode;
  assign funct3 = inst_i.r_fmt.funct3;
  assign alt    = inst_i.r_fmt.funct7[5];

  assign imm_i = {{(decode_pkg::XLEN-12){inst_i.i_fmt.imm12[11]}}, inst_i.i_fmt.imm12};
  assign imm_s = {{(decode_pkg::XLEN-12){inst_i.s_fmt.imm_hi[6]}},
                  inst_i.s_fmt.imm_hi, inst_i.s_fmt.imm_lo};
  assign imm_b = {{(decode_pkg::XLEN-12){inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_lo[0],
                  inst_i.s_fmt.imm_hi[5:0], inst_i.s_fmt.imm_lo[4:1], 1'b0};
  assign imm_u = {{(decode_pkg::XLEN-32){inst_i.u_fmt.imm20[19]}}, inst_i.u_fmt.imm20, 12'b0};
  // j immediate bits sit in the u field in scrambled order
  assign imm_j = {{(decode_pkg::XLEN-20){inst_i.u_fmt.imm20[19]}}, inst_i.u_fmt.imm20[7:0],
                  inst_i.u_fmt.imm20[8], inst_i.u_fmt.imm20[18:9], 1'b0};

  always_comb begin
    d.op      = decode_pkg::OP_NOP;
    d.use_pc  = 1'b0;
    d.use_imm = 1'b0;
    d.imm     = '0;
    rs1_rd    = 1'b0;
    rs2_rd    = 1'b0;
    wr        = 1'b0;
    case (opcode)
      decode_pkg::OPC_OP: begin
        // only funct7 0000000, or 0100000 for add/sub and srl/sra
        if ({inst_i.r_fmt.funct7[6], inst_i.r_fmt.funct7[4:0]} == 6'b0 &&
            (!alt || funct3 == 3'b000 || funct3 == 3'b101)) begin
          d.op   = alu_op(funct3, alt);
          rs1_rd = 1'b1;
          rs2_rd = 1'b1;
          wr     = 1'b1;
        end
      end
      decode_pkg::OPC_OPIMM: begin
        // shifts carry a 6-bit shamt, upper bits must be clean
        if (funct3[1:0] != 2'b01 ||
            ({inst_i.r_fmt.funct7[6], inst_i.r_fmt.funct7[4:1]} == 5'b0 &&
             (funct3[2] || !alt))) begin
          d.op      = alu_op(funct3, funct3 == 3'b101 && alt);
          d.use_imm = 1'b1;
          d.imm     = imm_i;
          rs1_rd    = 1'b1;
          wr        = 1'b1;
        end
      end
      decode_pkg::OPC_LUI: begin
        d.op      = decode_pkg::OP_LUI;
        d.use_imm = 1'b1;
        d.imm     = imm_u;
        wr        = 1'b1;
      end
      decode_pkg::OPC_AUIPC: begin
        d.op      = decode_pkg::OP_AUIPC;
        d.use_pc  = 1'b1;
        d.use_imm = 1'b1;
        d.imm     = imm_u;
        wr        = 1'b1;
      end
      decode_pkg::OPC_JAL: begin
        d.op     = decode_pkg::OP_JAL;
        d.use_pc = 1'b1;
        d.imm    = imm_j;
        wr       = 1'b1;
      end
      decode_pkg::OPC_JALR: begin
        if (funct3 == 3'b000) begin
          d.op   = decode_pkg::OP_JALR;
          d.imm  = imm_i;
          rs1_rd = 1'b1;
          wr     = 1'b1;
        end
      end
      decode_pkg::OPC_BRANCH: begin
        if (funct3[2:1] != 2'b01) begin
          case (funct3)
            3'b000:  d.op = decode_pkg::OP_BEQ;
            3'b001:  d.op = decode_pkg::OP_BNE;
            3'b100:  d.op = decode_pkg::OP_BLT;
            3'b101:  d.op = decode_pkg::OP_BGE;
            3'b110:  d.op = decode_pkg::OP_BLTU;
            default: d.op = decode_pkg::OP_BGEU;
          endcase
          d.imm  = imm_b;
          rs1_rd = 1'b1;
          rs2_rd = 1'b1;
        end
      end
      decode_pkg::OPC_LOAD: begin
        // no 128-bit or ldu form in rv64i
        if (funct3 != 3'b111) begin
          d.op      = decode_pkg::OP_LOAD;
          d.use_imm = 1'b1;
          d.imm     = imm_i;
          rs1_rd    = 1'b1;
          wr        = 1'b1;
        end
      end
      decode_pkg::OPC_STORE: begin
        if (!funct3[2]) begin
          d.op   = decode_pkg::OP_STORE;
          d.imm  = imm_s;
          rs1_rd = 1'b1;
          rs2_rd = 1'b1;
        end
      end
      default: ;
    endcase
  end

  assign d.rs1_read = rs1_rd;
  assign d.rs2_read = rs2_rd;
  assign d.rs1_addr = rs1_rd ? inst_i.r_fmt.rs1 : '0;
  assign d.rs2_addr = rs2_rd ? inst_i.r_fmt.rs2 : '0;
  assign d.rd_addr  = inst_i.r_fmt.rd;
  assign d.rd_we    = wr && (inst_i.r_fmt.rd != '0);
  assign d.funct3   = funct3;

  // a rejected encoding claims no register
  always_comb begin
    assert (d.op != decode_pkg::OP_NOP || (!d.rs1_read && !d.rs2_read && !d.rd_we))
      else $error("decoder: unknown encoding uses a register");
  end

endmodule

`default_nettype wire

// File: design/operand_forward.sv
// ----------------------------------------------------------
// operand select with ex/mem bypass and load-use stall
// ----------------------------------------------------------
`default_nettype none

module operand_forward (
  dec_if.user                           d,
  input  logic [decode_pkg::XLEN-1:0]   pc_i,
  input  logic [decode_pkg::XLEN-1:0]   rs1_data_i,
  input  logic [decode_pkg::XLEN-1:0]   rs2_data_i,
  input  logic                          ex_rd_we_i,
  input  logic                          ex_is_load_i,
  input  logic [decode_pkg::REG_AW-1:0] ex_rd_addr_i,
  input  logic [decode_pkg::XLEN-1:0]   ex_rd_data_i,
  input  logic                          mem_rd_we_i,
  input  logic [decode_pkg::REG_AW-1:0] mem_rd_addr_i,
  input  logic [decode_pkg::XLEN-1:0]   mem_rd_data_i,
  input  logic                          reset_i,
  output logic [decode_pkg::XLEN-1:0]   op1_o,
  output logic [decode_pkg::XLEN-1:0]   op2_o,
  output logic                          stall_o
);

  logic                        ex_hit1, ex_hit2;
  logic                        mem_hit1, mem_hit2;
  logic                        is_jump;
  logic [decode_pkg::XLEN-1:0] rs1_val, rs2_val;

  // x0 and unread sources never match a bypass
  assign ex_hit1  = d.rs1_read && d.rs1_addr != '0 && ex_rd_we_i && ex_rd_addr_i == d.rs1_addr;
  assign ex_hit2  = d.rs2_read && d.rs2_addr != '0 && ex_rd_we_i && ex_rd_addr_i == d.rs2_addr;
  assign mem_hit1 = d.rs1_read && d.rs1_addr != '0 && mem_rd_we_i &&
                    mem_rd_addr_i == d.rs1_addr;
  assign mem_hit2 = d.rs2_read && d.rs2_addr != '0 && mem_rd_we_i &&
                    mem_rd_addr_i == d.rs2_addr;

  // ex result only usable when it is not a load
  assign rs1_val = (ex_hit1 && !ex_is_load_i) ? ex_rd_data_i :
                   mem_hit1                   ? mem_rd_data_i : rs1_data_i;
  assign rs2_val = (ex_hit2 && !ex_is_load_i) ? ex_rd_data_i :
                   mem_hit2                   ? mem_rd_data_i : rs2_data_i;

  assign is_jump = d.op == decode_pkg::OP_JAL || d.op == decode_pkg::OP_JALR;

  // lui falls through to zero on op1
  assign op1_o = d.rs1_read ? rs1_val :
                 d.use_pc   ? pc_i    : '0;
  // jumps carry the link value
  assign op2_o = d.rs2_read ? rs2_val   :
                 is_jump    ? pc_i + 64'd4 :
                 d.use_imm  ? d.imm     : '0;

  assign stall_o = !reset_i && ex_is_load_i && (ex_hit1 || ex_hit2);

  // x0 sources always see the register file value
  always_comb begin
    assert ((!(d.rs1_read && d.rs1_addr == '0) || op1_o == rs1_data_i) &&
            (!(d.rs2_read && d.rs2_addr == '0) || op2_o == rs2_data_i))
      else $error("forward: x0 source took a bypass value");
  end

endmodule

`default_nettype wire

// File: design/branch_resolve.sv
// ----------------------------------------------------------
// branch compare and jalr target, redirect on mispredict
// ----------------------------------------------------------
`default_nettype none

module branch_resolve (
  dec_if.user                         d,
  input  decode_pkg::inst_word_u      inst_i,
  input  logic [decode_pkg::XLEN-1:0] pc_i,
  input  logic [decode_pkg::XLEN-1:0] op1_i,
  input  logic [decode_pkg::XLEN-1:0] op2_i,
  input  logic                        pred_taken_i,
  input  logic                        stall_i,
  input  logic                        reset_i,
  output logic                        redirect_o,
  output logic [decode_pkg::XLEN-1:0] redirect_pc_o
);

  logic                        is_branch;
  logic                        is_jalr;
  logic                        taken;
  logic [decode_pkg::XLEN-1:0] b_imm;
  logic [decode_pkg::XLEN-1:0] jalr_sum;

  assign b_imm = {{(decode_pkg::XLEN-12){inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_lo[0],
                  inst_i.s_fmt.imm_hi[5:0], inst_i.s_fmt.imm_lo[4:1], 1'b0};

  always_comb begin
    is_branch = 1'b1;
    taken     = 1'b0;
    case (d.op)
      decode_pkg::OP_BEQ:  taken = op1_i == op2_i;
      decode_pkg::OP_BNE:  taken = op1_i != op2_i;
      decode_pkg::OP_BLT:  taken = $signed(op1_i) < $signed(op2_i);
      decode_pkg::OP_BGE:  taken = $signed(op1_i) >= $signed(op2_i);
      decode_pkg::OP_BLTU: taken = op1_i < op2_i;
      decode_pkg::OP_BGEU: taken = op1_i >= op2_i;
      default:             is_branch = 1'b0;
    endcase
  end

  assign is_jalr  = d.op == decode_pkg::OP_JALR;
  assign jalr_sum = op1_i + d.imm;

  // jalr is never predicted here, so it always redirects
  assign redirect_o = ((is_branch && taken != pred_taken_i) || is_jalr) &&
                      !stall_i && !reset_i;

  assign redirect_pc_o = is_jalr ? {jalr_sum[decode_pkg::XLEN-1:1], 1'b0} :
                         taken   ? pc_i + b_imm : pc_i + 64'd4;

  always_comb begin
    assert (!redirect_o || !redirect_pc_o[0])
      else $error("branch: redirect target is odd");
  end

endmodule

`default_nettype wire

// File: design/id_ex_reg.sv
// ----------------------------------------------------------
// decode to execute pipeline register, bubble on stall
// ----------------------------------------------------------
`default_nettype none

module id_ex_reg (
  input  logic                          clk,
  input  logic                          reset_i,
  dec_if.user                           d,
  input  logic                          stall_i,
  input  logic [decode_pkg::XLEN-1:0]   pc_i,
  input  logic [decode_pkg::XLEN-1:0]   op1_i,
  input  logic [decode_pkg::XLEN-1:0]   op2_i,
  output logic                          ex_valid_o,
  output logic [decode_pkg::OP_W-1:0]   ex_op_o,
  output logic [decode_pkg::XLEN-1:0]   ex_op1_o,
  output logic [decode_pkg::XLEN-1:0]   ex_op2_o,
  output logic [decode_pkg::XLEN-1:0]   ex_imm_o,
  output logic [decode_pkg::XLEN-1:0]   ex_pc_o,
  output logic [2:0]                    ex_funct3_o,
  output logic                          ex_rd_we_o,
  output logic [decode_pkg::REG_AW-1:0] ex_rd_addr_o
);

  // bubble is valid low, nop and no write
  always_ff @(posedge clk) begin
    if (reset_i || stall_i) begin
      ex_valid_o <= 1'b0;
      ex_op_o    <= decode_pkg::OP_NOP;
      ex_rd_we_o <= 1'b0;
    end else begin
      ex_valid_o <= 1'b1;
      ex_op_o    <= d.op;
      ex_rd_we_o <= d.rd_we;
    end
  end

  always_ff @(posedge clk) begin
    ex_op1_o     <= op1_i;
    ex_op2_o     <= op2_i;
    ex_imm_o     <= d.imm;
    ex_pc_o      <= pc_i;
    ex_funct3_o  <= d.funct3;
    ex_rd_addr_o <= d.rd_addr;
  end

  // execute never sees a write to x0
  a_no_x0_write : assert property (@(posedge clk) ex_rd_we_o |-> ex_rd_addr_o != '0)
    else $error("id_ex: write to x0 reached execute");

endmodule

`default_nettype wire

// File: design/decode_stage.sv
// ----------------------------------------------------------
// rv64i decode stage top: decoder, bypass, branch resolve
// and the execute-stage register
// ----------------------------------------------------------
`default_nettype none

module decode_stage (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic [decode_pkg::INST_W-1:0] inst_i,
  input  logic [decode_pkg::XLEN-1:0]   pc_i,
  input  logic                          pred_taken_i,
  input  logic [decode_pkg::XLEN-1:0]   rs1_data_i,
  input  logic [decode_pkg::XLEN-1:0]   rs2_data_i,
  input  logic                          ex_rd_we_i,
  input  logic [decode_pkg::REG_AW-1:0] ex_rd_addr_i,
  input  logic [decode_pkg::XLEN-1:0]   ex_rd_data_i,
  input  logic                          ex_is_load_i,
  input  logic                          mem_rd_we_i,
  input  logic [decode_pkg::REG_AW-1:0] mem_rd_addr_i,
  input  logic [decode_pkg::XLEN-1:0]   mem_rd_data_i,
  output logic [decode_pkg::REG_AW-1:0] rs1_addr_o,
  output logic [decode_pkg::REG_AW-1:0] rs2_addr_o,
  output logic                          rs1_read_o,
  output logic                          rs2_read_o,
  output logic                          stall_o,
  output logic                          redirect_o,
  output logic [decode_pkg::XLEN-1:0]   redirect_pc_o,
  output logic                          ex_valid_o,
  output logic [decode_pkg::OP_W-1:0]   ex_op_o,
  output logic [decode_pkg::XLEN-1:0]   ex_op1_o,
  output logic [decode_pkg::XLEN-1:0]   ex_op2_o,
  output logic [decode_pkg::XLEN-1:0]   ex_imm_o,
  output logic [decode_pkg::XLEN-1:0]   ex_pc_o,
  output logic [2:0]                    ex_funct3_o,
  output logic                          ex_rd_we_o,
  output logic [decode_pkg::REG_AW-1:0] ex_rd_addr_o
);

  logic [decode_pkg::XLEN-1:0] op1;
  logic [decode_pkg::XLEN-1:0] op2;

  dec_if u_dec_if ();

  inst_decoder u_decoder (
    .inst_i (inst_i),
    .d      (u_dec_if)
  );

  // register file addresses go straight out
  assign rs1_addr_o = u_dec_if.rs1_addr;
  assign rs2_addr_o = u_dec_if.rs2_addr;
  assign rs1_read_o = u_dec_if.rs1_read;
  assign rs2_read_o = u_dec_if.rs2_read;

  operand_forward u_forward (
    .d             (u_dec_if),
    .pc_i          (pc_i),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .ex_rd_we_i    (ex_rd_we_i),
    .ex_is_load_i  (ex_is_load_i),
    .ex_rd_addr_i  (ex_rd_addr_i),
    .ex_rd_data_i  (ex_rd_data_i),
    .mem_rd_we_i   (mem_rd_we_i),
    .mem_rd_addr_i (mem_rd_addr_i),
    .mem_rd_data_i (mem_rd_data_i),
    .reset_i       (reset_i),
    .op1_o         (op1),
    .op2_o         (op2),
    .stall_o       (stall_o)
  );

  branch_resolve u_branch (
    .d             (u_dec_if),
    .inst_i        (inst_i),
    .pc_i          (pc_i),
    .op1_i         (op1),
    .op2_i         (op2),
    .pred_taken_i  (pred_taken_i),
    .stall_i       (stall_o),
    .reset_i       (reset_i),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

  id_ex_reg u_id_ex (
    .clk          (clk),
    .reset_i      (reset_i),
    .d            (u_dec_if),
    .stall_i      (stall_o),
    .pc_i         (pc_i),
    .op1_i        (op1),
    .op2_i        (op2),
    .ex_valid_o   (ex_valid_o),
    .ex_op_o      (ex_op_o),
    .ex_op1_o     (ex_op1_o),
    .ex_op2_o     (ex_op2_o),
    .ex_imm_o     (ex_imm_o),
    .ex_pc_o      (ex_pc_o),
    .ex_funct3_o  (ex_funct3_o),
    .ex_rd_we_o   (ex_rd_we_o),
    .ex_rd_addr_o (ex_rd_addr_o)
  );

endmodule

`default_nettype wire

// File: bench/tb_decode_stage.sv
// ----------------------------------------------------------
// decode stage testbench: vector-driven checks of decode,
// bypass, load-use stall, branches and jumps
// ----------------------------------------------------------
`default_nettype none

module tb_decode_stage;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_VEC = 21;
  localparam int FIELDS  = 20;

  typedef struct packed {
    logic [31:0] inst;
    logic [63:0] pc;
    logic        pred;
    logic [63:0] rs1_data;
    logic [63:0] rs2_data;
    logic        ex_we;
    logic [4:0]  ex_addr;
    logic [63:0] ex_data;
    logic        ex_load;
    logic        mem_we;
    logic [4:0]  mem_addr;
    logic [63:0] mem_data;
    logic        exp_stall;
    logic        exp_redirect;
    logic [63:0] exp_target;
    logic [4:0]  exp_op;
    logic [63:0] exp_op1;
    logic [63:0] exp_op2;
    logic        exp_rd_we;
    logic [4:0]  exp_rd;
  } vector_t;

  logic        clk;
  logic        reset_i;
  logic [31:0] inst_i;
  logic [63:0] pc_i, rs1_data_i, rs2_data_i, ex_rd_data_i, mem_rd_data_i;
  logic        pred_taken_i, ex_rd_we_i, ex_is_load_i, mem_rd_we_i;
  logic [4:0]  ex_rd_addr_i, mem_rd_addr_i;
  logic [4:0]  rs1_addr_o, rs2_addr_o, ex_op_o, ex_rd_addr_o;
  logic        rs1_read_o, rs2_read_o, stall_o, redirect_o;
  logic        ex_valid_o, ex_rd_we_o;
  logic [63:0] redirect_pc_o, ex_op1_o, ex_op2_o, ex_imm_o, ex_pc_o;
  logic [2:0]  ex_funct3_o;

  logic [63:0] raw [0:NUM_VEC*FIELDS-1];
  vector_t     vec [0:NUM_VEC-1];
  logic        bad [0:NUM_VEC-1];
  logic        reset_bad;
  int          pass_count;
  int          fail_count;

  decode_stage u_dut (
    .clk (clk), .reset_i (reset_i), .inst_i (inst_i), .pc_i (pc_i),
    .pred_taken_i (pred_taken_i), .rs1_data_i (rs1_data_i), .rs2_data_i (rs2_data_i),
    .ex_rd_we_i (ex_rd_we_i), .ex_rd_addr_i (ex_rd_addr_i), .ex_rd_data_i (ex_rd_data_i),
    .ex_is_load_i (ex_is_load_i), .mem_rd_we_i (mem_rd_we_i),
    .mem_rd_addr_i (mem_rd_addr_i), .mem_rd_data_i (mem_rd_data_i),
    .rs1_addr_o (rs1_addr_o), .rs2_addr_o (rs2_addr_o), .rs1_read_o (rs1_read_o),
    .rs2_read_o (rs2_read_o), .stall_o (stall_o), .redirect_o (redirect_o),
    .redirect_pc_o (redirect_pc_o), .ex_valid_o (ex_valid_o), .ex_op_o (ex_op_o),
    .ex_op1_o (ex_op1_o), .ex_op2_o (ex_op2_o), .ex_imm_o (ex_imm_o), .ex_pc_o (ex_pc_o),
    .ex_funct3_o (ex_funct3_o), .ex_rd_we_o (ex_rd_we_o), .ex_rd_addr_o (ex_rd_addr_o)
  );

  always #5 clk = ~clk;

  // source register use by major opcode, bit 0 is rs1
  function automatic logic [1:0] source_reads(input logic [31:0] inst);
    case (inst[6:0])
      7'h33, 7'h63, 7'h23: source_reads = 2'b11;
      7'h13, 7'h67, 7'h03: source_reads = 2'b01;
      default:             source_reads = 2'b00;
    endcase
  endfunction

  // sign-extended immediate of the instruction format
  function automatic logic [63:0] format_imm(input logic [31:0] inst);
    case (inst[6:0])
      7'h13, 7'h03, 7'h67: format_imm = 64'($signed(inst[31:20]));
      7'h23:               format_imm = 64'($signed({inst[31:25], inst[11:7]}));
      7'h63: format_imm = 64'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
      7'h37, 7'h17:        format_imm = 64'($signed({inst[31:12], 12'h000}));
      7'h6f: format_imm = 64'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
      default:             format_imm = 64'd0;
    endcase
  endfunction

  task automatic report_mismatch(input int idx, input string name,
                                 input logic [63:0] exp_val, input logic [63:0] act_val);
    $display("FAIL at %0t ns: test %0d %s expected %h got %h",
             $time, idx, name, exp_val, act_val);
    if (idx < 0) begin
      reset_bad = 1'b1;
    end else begin
      bad[idx] = 1'b1;
    end
  endtask

  task automatic apply_vector(input vector_t v);
    inst_i        <= v.inst;
    pc_i          <= v.pc;
    pred_taken_i  <= v.pred;
    rs1_data_i    <= v.rs1_data;
    rs2_data_i    <= v.rs2_data;
    ex_rd_we_i    <= v.ex_we;
    ex_rd_addr_i  <= v.ex_addr;
    ex_rd_data_i  <= v.ex_data;
    ex_is_load_i  <= v.ex_load;
    mem_rd_we_i   <= v.mem_we;
    mem_rd_addr_i <= v.mem_addr;
    mem_rd_data_i <= v.mem_data;
  endtask

  task automatic check_comb(input int idx);
    vector_t    v;
    logic [1:0] reads;
    logic [4:0] want_rs1;
    logic [4:0] want_rs2;
    v = vec[idx];
    reads    = source_reads(v.inst);
    want_rs1 = reads[0] ? v.inst[19:15] : 5'd0;
    want_rs2 = reads[1] ? v.inst[24:20] : 5'd0;
    if (rs1_read_o !== reads[0]) begin
      report_mismatch(idx, "rs1_read_o", 64'(reads[0]), 64'(rs1_read_o));
    end
    if (rs2_read_o !== reads[1]) begin
      report_mismatch(idx, "rs2_read_o", 64'(reads[1]), 64'(rs2_read_o));
    end
    if (rs1_addr_o !== want_rs1) begin
      report_mismatch(idx, "rs1_addr_o", 64'(want_rs1), 64'(rs1_addr_o));
    end
    if (rs2_addr_o !== want_rs2) begin
      report_mismatch(idx, "rs2_addr_o", 64'(want_rs2), 64'(rs2_addr_o));
    end
    if (stall_o !== v.exp_stall) begin
      report_mismatch(idx, "stall_o", 64'(v.exp_stall), 64'(stall_o));
    end
    if (redirect_o !== v.exp_redirect) begin
      report_mismatch(idx, "redirect_o", 64'(v.exp_redirect), 64'(redirect_o));
    end
    if (v.exp_redirect && redirect_pc_o !== v.exp_target) begin
      report_mismatch(idx, "redirect_pc_o", v.exp_target, redirect_pc_o);
    end
  endtask

  task automatic check_ex(input int idx);
    vector_t     v;
    logic        want_valid;
    logic [4:0]  want_op;
    logic        want_we;
    logic [63:0] want_imm;
    v = vec[idx];
    // a stalled instruction leaves a bubble in execute
    want_valid = !v.exp_stall;
    want_op    = v.exp_stall ? decode_pkg::OP_NOP : v.exp_op;
    want_we    = v.exp_rd_we && !v.exp_stall;
    want_imm   = format_imm(v.inst);
    if (ex_valid_o !== want_valid) begin
      report_mismatch(idx, "ex_valid_o", 64'(want_valid), 64'(ex_valid_o));
    end
    if (ex_op_o !== want_op) begin
      report_mismatch(idx, "ex_op_o", 64'(want_op), 64'(ex_op_o));
    end
    if (ex_op1_o !== v.exp_op1) begin
      report_mismatch(idx, "ex_op1_o", v.exp_op1, ex_op1_o);
    end
    if (ex_op2_o !== v.exp_op2) begin
      report_mismatch(idx, "ex_op2_o", v.exp_op2, ex_op2_o);
    end
    if (ex_imm_o !== want_imm) begin
      report_mismatch(idx, "ex_imm_o", want_imm, ex_imm_o);
    end
    if (ex_pc_o !== v.pc) begin
      report_mismatch(idx, "ex_pc_o", v.pc, ex_pc_o);
    end
    if (ex_funct3_o !== v.inst[14:12]) begin
      report_mismatch(idx, "ex_funct3_o", 64'(v.inst[14:12]), 64'(ex_funct3_o));
    end
    if (ex_rd_we_o !== want_we) begin
      report_mismatch(idx, "ex_rd_we_o", 64'(want_we), 64'(ex_rd_we_o));
    end
    if (want_we && ex_rd_addr_o !== v.exp_rd) begin
      report_mismatch(idx, "ex_rd_addr_o", 64'(v.exp_rd), 64'(ex_rd_addr_o));
    end
    if (bad[idx]) begin
      fail_count++;
      $display("test %0d inst %h: FAIL", idx, v.inst);
    end else begin
      pass_count++;
      $display("test %0d inst %h: PASS", idx, v.inst);
    end
  endtask

  // run length is reset plus one cycle per vector, with margin
  initial begin
    #((NUM_VEC + 20) * 10);
    $display("timeout: the vectors did not complete within %0d cycles", NUM_VEC + 20);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int      b;
    vector_t v;
    clk = 1'b0;
    reset_i = 1'b1;
    inst_i = '0;
    pc_i = '0;
    pred_taken_i = 1'b0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    ex_rd_we_i = 1'b0;
    ex_rd_addr_i = '0;
    ex_rd_data_i = '0;
    ex_is_load_i = 1'b0;
    mem_rd_we_i = 1'b0;
    mem_rd_addr_i = '0;
    mem_rd_data_i = '0;
    reset_bad = 1'b0;
    pass_count = 0;
    fail_count = 0;
    $readmemh("bench/decode_vectors.txt", raw);
    if ($isunknown(raw[0])) begin
      $display("ERROR: the vector file could not be read");
      fail_count++;
    end
    for (int i = 0; i < NUM_VEC; i++) begin
      b = i * FIELDS;
      v.inst = raw[b][31:0];
      v.pc = raw[b+1];
      v.pred = raw[b+2][0];
      v.rs1_data = raw[b+3];
      v.rs2_data = raw[b+4];
      v.ex_we = raw[b+5][0];
      v.ex_addr = raw[b+6][4:0];
      v.ex_data = raw[b+7];
      v.ex_load = raw[b+8][0];
      v.mem_we = raw[b+9][0];
      v.mem_addr = raw[b+10][4:0];
      v.mem_data = raw[b+11];
      v.exp_stall = raw[b+12][0];
      v.exp_redirect = raw[b+13][0];
      v.exp_target = raw[b+14];
      v.exp_op = raw[b+15][4:0];
      v.exp_op1 = raw[b+16];
      v.exp_op2 = raw[b+17];
      v.exp_rd_we = raw[b+18][0];
      v.exp_rd = raw[b+19][4:0];
      vec[i] = v;
      bad[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    if (ex_valid_o !== 1'b0) begin
      report_mismatch(-1, "ex_valid_o", 64'd0, 64'(ex_valid_o));
    end
    if (ex_op_o !== decode_pkg::OP_NOP) begin
      report_mismatch(-1, "ex_op_o", 64'(decode_pkg::OP_NOP), 64'(ex_op_o));
    end
    if (reset_bad) begin
      fail_count++;
      $display("test reset: FAIL");
    end else begin
      pass_count++;
      $display("test reset: PASS");
    end
    // one vector per cycle, execute results checked a cycle later
    for (int i = 0; i < NUM_VEC; i++) begin
      @(posedge clk);
      apply_vector(vec[i]);
      @(negedge clk);
      if (i > 0) begin
        check_ex(i - 1);
      end
      check_comb(i);
    end
    @(posedge clk);
    @(negedge clk);
    check_ex(NUM_VEC - 1);
    $display("passed %0d, failed %0d of %0d tests", pass_count, fail_count, NUM_VEC + 1);
    if (fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/decode_vectors.txt
// in: inst pc pred rs1_data rs2_data ex_we ex_addr ex_data ex_load mem_we mem_addr mem_data
// exp: stall redirect redirect_pc op op1 op2 rd_we rd_addr (all hex, 20 fields per line)
002081b3 1000 0 11 22 0 0 0 0 0 0 0 0 0 0 1 11 22 1 3
407302b3 1004 0 5 8 0 0 0 0 0 0 0 0 0 0 2 5 8 1 5
40b554b3 1008 0 8000000000000000 4 0 0 0 0 0 0 0 0 0 0 8 8000000000000000 4 1 9
fff6a613 100c 0 33 0 0 0 0 0 0 0 0 0 0 0 4 33 ffffffffffffffff 1 c
7f07f713 1010 0 44 0 0 0 0 0 0 0 0 0 0 0 a 44 7f0 1 e
002081b3 1014 0 11 22 1 1 e0 0 1 1 d0 0 0 0 1 e0 22 1 3
002081b3 1018 0 11 22 1 5 e0 0 1 2 d0 0 0 0 1 11 d0 1 3
002001b3 101c 0 11 22 1 0 e0 1 1 0 d0 0 0 0 1 11 22 1 3
002081b3 1020 0 11 22 1 2 e0 1 0 0 0 1 0 0 1 11 22 1 3
002081b3 1020 0 11 22 1 2 e0 0 0 0 0 0 0 0 1 11 e0 1 3
00208863 2000 1 8000000000000000 8000000000000000 0 0 0 0 0 0 0 0 0 2010 f 8000000000000000 8000000000000000 0 0
00209863 2000 0 8000000000000000 7fffffffffffffff 0 0 0 0 0 0 0 0 1 2010 10 8000000000000000 7fffffffffffffff 0 0
0020c863 2000 0 8000000000000000 7fffffffffffffff 0 0 0 0 0 0 0 0 1 2010 11 8000000000000000 7fffffffffffffff 0 0
0020d863 2000 1 ffffffffffffffff 0 0 0 0 0 0 0 0 0 1 2004 12 ffffffffffffffff 0 0 0
fe20e8e3 2000 0 7fffffffffffffff 8000000000000000 0 0 0 0 0 0 0 0 1 1ff0 13 7fffffffffffffff 8000000000000000 0 0
0020f863 2000 0 ffffffffffffffff 8000000000000000 0 0 0 0 0 0 0 0 1 2010 14 ffffffffffffffff 8000000000000000 0 0
00209863 2004 0 1 2 1 1 e0 1 0 0 0 1 0 0 10 1 2 0 0
008280e7 3000 0 4001 0 0 0 0 0 0 0 0 0 1 4008 e 4001 3004 1 1
100000ef 3000 0 0 0 0 0 0 0 0 0 0 0 0 0 d 3000 3004 1 1
800003b7 3000 0 0 0 0 0 0 0 0 0 0 0 0 0 b 0 ffffffff80000000 1 7
12345417 3000 0 0 0 0 0 0 0 0 0 0 0 0 0 c 3000 12345000 1 8

// File: vlog.f
design/decode_pkg.sv
design/dec_if.sv
design/inst_decoder.sv
design/operand_forward.sv
design/branch_resolve.sv
design/id_ex_reg.sv
design/decode_stage.sv
bench/tb_decode_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the decode stage testbench with verilator
cd "$(dirname "$0")" || exit 1
mkdir -p build || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f vlog.f --top-module tb_decode_stage -Mdir build/obj -o tb_decode_stage \
  > build/compile.log 2>&1 || { cat build/compile.log; echo "build failed"; exit 1; }
build/obj/tb_decode_stage > build/sim.log 2>&1
cat build/sim.log
grep -q "Some tests failed" build/sim.log && { echo "simulation reported failures"; exit 1; }
grep -q "All tests passed" build/sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
